// File: rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [11:0] csr_addr_t;

  //////////////////////////////////////////////////
  // machine-mode CSR addresses
  //////////////////////////////////////////////////
  localparam csr_addr_t CSR_MSTATUS       = 12'h300;
  localparam csr_addr_t CSR_MTVEC         = 12'h305;
  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
  localparam csr_addr_t CSR_MEPC          = 12'h341;
  localparam csr_addr_t CSR_MCAUSE        = 12'h342;
  localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
  localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
  localparam csr_addr_t CSR_MVENDORID     = 12'hf11;
  localparam csr_addr_t CSR_MARCHID       = 12'hf12;

  //////////////////////////////////////////////////
  // mstatus layout
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [18:0] rsvd_31_13;
    logic [1:0]  mpp;        // 12:11
    logic [2:0]  rsvd_10_8;
    logic        mpie;       // 7
    logic [2:0]  rsvd_6_4;
    logic        mie;        // 3
    logic [2:0]  rsvd_2_0;
  } mstatus_fields_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    mstatus_fields_t f;
  } mstatus_t;

  typedef logic [XLEN-1:0] cause_t;

  localparam cause_t CAUSE_ECALL_M = 32'd11; // environment call from M-mode

endpackage

`default_nettype wire

// File: rtl/csr_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_wr_if import csr_pkg::*; ();

  logic            wen;    // slot one
  csr_addr_t       waddr;
  logic [XLEN-1:0] wdata;
  logic            wen2;   // slot two
  csr_addr_t       waddr2;
  logic [XLEN-1:0] wdata2;
  csr_addr_t       raddr;
  logic [XLEN-1:0] rdata;
  logic            rvalid; // raddr is a known CSR
  logic            wr_ok;  // waddr is writable

  modport master (
    output wen, waddr, wdata,
    output wen2, waddr2, wdata2,
    output raddr,
    input  rdata, rvalid, wr_ok
  );

  modport file (
    input  wen, waddr, wdata,
    input  wen2, waddr2, wdata2,
    input  raddr,
    output rdata, rvalid, wr_ok
  );

endinterface

`default_nettype wire

// File: rtl/csr_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module csr_apb_slave import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  csr_addr_t       paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [XLEN-1:0] pwdata,
  output logic [XLEN-1:0] prdata,
  output logic            pready,
  output logic            pslverr,
  csr_wr_if.master        host,
  input  logic            grant
);

  logic in_access; // setup phase seen, transfer not yet done
  logic access;
  logic done;

  //////////////////////////////////////////////////
  // transfer tracking
  //////////////////////////////////////////////////
  assign access = psel && penable && in_access;
  assign done   = access && grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_access <= 1'b0;
    end else if (!psel) begin
      in_access <= 1'b0;
    end else if (!penable) begin
      in_access <= 1'b1; // setup phase
    end else if (done) begin
      in_access <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // request to register file
  //////////////////////////////////////////////////
  assign host.raddr  = paddr;
  assign host.waddr  = paddr;
  assign host.wdata  = pwdata;
  assign host.wen    = done && pwrite; // one write per transfer
  assign host.wen2   = 1'b0;           // host only uses slot one
  assign host.waddr2 = '0;
  assign host.wdata2 = '0;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////
  assign pready = done;

  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (done) begin
      if (pwrite) begin
        pslverr = !host.wr_ok; // read-only or unknown
      end else begin
        prdata  = host.rdata;
        pslverr = !host.rvalid;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/trap_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module trap_fsm import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  csr_wr_if.file          host,
  csr_wr_if.master        csr,
  input  logic            trap_req,
  input  logic            mret_req,
  input  logic [XLEN-1:0] trap_pc,
  input  cause_t          trap_cause,
  output logic            trap_ack,
  output logic            redirect_valid,
  output logic [XLEN-1:0] redirect_pc,
  input  logic [XLEN-1:0] mtvec,
  input  logic [XLEN-1:0] mepc,
  output mstatus_t        mstatus_upd,
  output logic            mstatus_we,
  output logic            cnt_we_lo,
  output logic            cnt_we_hi,
  output logic [XLEN-1:0] cnt_wdata,
  input  logic [XLEN-1:0] cnt_rdata_lo,
  input  logic [XLEN-1:0] cnt_rdata_hi,
  output logic            grant
);

  localparam logic IDLE   = 1'b0;
  localparam logic COMMIT = 1'b1;

  logic     state;
  logic     is_trap;  // trap beats mret
  mstatus_t cur;
  logic     wa_lo;
  logic     wa_hi;
  logic     ra_lo;
  logic     ra_hi;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      is_trap <= 1'b0;
    end else if (state == IDLE) begin
      if (trap_req || mret_req) begin
        state   <= COMMIT;
        is_trap <= trap_req;
      end
    end else begin
      state <= IDLE;
    end
  end

  assign grant          = (state == IDLE);
  assign trap_ack       = (state == COMMIT);
  assign redirect_valid = (state == COMMIT);
  assign redirect_pc    = is_trap ? mtvec : mepc;

  //////////////////////////////////////////////////
  // mcycle steering
  //////////////////////////////////////////////////
  assign wa_lo     = (host.waddr == CSR_MCYCLE);
  assign wa_hi     = (host.waddr == CSR_MCYCLEH);
  assign ra_lo     = (host.raddr == CSR_MCYCLE);
  assign ra_hi     = (host.raddr == CSR_MCYCLEH);
  assign cnt_we_lo = grant && host.wen && wa_lo;
  assign cnt_we_hi = grant && host.wen && wa_hi;
  assign cnt_wdata = host.wdata;

  assign host.rdata  = ra_lo ? cnt_rdata_lo : (ra_hi ? cnt_rdata_hi : csr.rdata);
  assign host.rvalid = ra_lo || ra_hi || csr.rvalid;
  assign host.wr_ok  = wa_lo || wa_hi || csr.wr_ok;

  //////////////////////////////////////////////////
  // register file port
  //////////////////////////////////////////////////
  assign csr.raddr = (state == COMMIT) ? CSR_MSTATUS : host.raddr; // old mstatus in commit
  assign cur.raw   = csr.rdata;

  always_comb begin
    csr.wen     = grant && host.wen && !(wa_lo || wa_hi);
    csr.waddr   = host.waddr;
    csr.wdata   = host.wdata;
    csr.wen2    = grant && host.wen2;
    csr.waddr2  = host.waddr2;
    csr.wdata2  = host.wdata2;
    mstatus_upd = cur;
    mstatus_we  = (state == COMMIT);
    if (state == COMMIT) begin
      if (is_trap) begin
        csr.wen     = 1'b1;
        csr.waddr   = CSR_MEPC;
        csr.wdata   = {trap_pc[XLEN-1:2], 2'b00};
        csr.wen2    = 1'b1;
        csr.waddr2  = CSR_MCAUSE;
        csr.wdata2  = trap_cause;
        mstatus_upd.f.mpie = cur.f.mie;
        mstatus_upd.f.mie  = 1'b0;
      end else begin
        mstatus_upd.f.mie  = cur.f.mpie; // mret
        mstatus_upd.f.mpie = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_counter import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            inhibit,
  input  logic            we_lo,
  input  logic            we_hi,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] count_lo,
  output logic [XLEN-1:0] count_hi
);

  logic [2*XLEN-1:0] count;

  assign count_lo = count[XLEN-1:0];
  assign count_hi = count[2*XLEN-1:XLEN];

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (we_lo || we_hi) begin
      // a load holds off the increment
      if (we_lo) begin
        count[XLEN-1:0] <= wdata;
      end
      if (we_hi) begin
        count[2*XLEN-1:XLEN] <= wdata;
      end
    end else if (!inhibit) begin
      count <= count + 1'b1; // carries into upper half
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; #(
  parameter logic [XLEN-1:0] VENDOR_ID = 32'h79737978,
  parameter logic [XLEN-1:0] ARCH_ID   = 32'h015fde77
) (
  input  logic            clk,
  input  logic            rst,
  csr_wr_if.file          port,
  input  mstatus_t        mstatus_upd,
  input  logic            mstatus_we,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] mepc,
  output mstatus_t        mstatus,
  output logic [XLEN-1:0] mcountinhibit
);

  localparam int NSLOT             = 5;
  localparam int SLOT_MSTATUS      = 0;
  localparam int SLOT_MTVEC        = 1;
  localparam int SLOT_MEPC         = 2;
  localparam int SLOT_MCAUSE       = 3;
  localparam int SLOT_MCOUNTINHIBIT = 4;

  logic [XLEN-1:0]  regs [NSLOT];
  logic [NSLOT-1:0] wslot1; // one-hot per write slot
  logic [NSLOT-1:0] wslot2;
  logic [NSLOT-1:0] rslot;
  logic             rd_vendor;
  logic             rd_arch;
  logic [XLEN-1:0]  rdata;

  function automatic logic [NSLOT-1:0] decode(csr_addr_t a);
    logic [NSLOT-1:0] s;
    s                     = '0;
    s[SLOT_MSTATUS]       = (a == CSR_MSTATUS);
    s[SLOT_MTVEC]         = (a == CSR_MTVEC);
    s[SLOT_MEPC]          = (a == CSR_MEPC);
    s[SLOT_MCAUSE]        = (a == CSR_MCAUSE);
    s[SLOT_MCOUNTINHIBIT] = (a == CSR_MCOUNTINHIBIT);
    return s;
  endfunction

  // WARL handling per slot
  function automatic logic [XLEN-1:0] legalize(int slot, logic [XLEN-1:0] d);
    mstatus_t src;
    mstatus_t m;
    src.raw = d;
    m.raw   = '0;
    case (slot)
      SLOT_MSTATUS: begin
        m.f.mie  = src.f.mie;
        m.f.mpie = src.f.mpie;
        m.f.mpp  = src.f.mpp;
        return m.raw;
      end
      SLOT_MTVEC, SLOT_MEPC: return {d[XLEN-1:2], 2'b00}; // direct mode, aligned
      default: return d;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  assign wslot1     = port.wen ? decode(port.waddr) : '0;
  assign wslot2     = port.wen2 ? decode(port.waddr2) : '0;
  assign port.wr_ok = |decode(port.waddr);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NSLOT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NSLOT; i++) begin
        if (wslot2[i]) begin
          regs[i] <= legalize(i, port.wdata2);
        end else if (wslot1[i]) begin
          regs[i] <= legalize(i, port.wdata);
        end
      end
      if (mstatus_we) begin
        regs[SLOT_MSTATUS] <= legalize(SLOT_MSTATUS, mstatus_upd.raw); // trap/mret wins
      end
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////
  assign rslot     = decode(port.raddr);
  assign rd_vendor = (port.raddr == CSR_MVENDORID);
  assign rd_arch   = (port.raddr == CSR_MARCHID);

  always_comb begin
    rdata = ({XLEN{rd_vendor}} & VENDOR_ID) | ({XLEN{rd_arch}} & ARCH_ID);
    for (int i = 0; i < NSLOT; i++) begin
      rdata = rdata | ({XLEN{rslot[i]}} & regs[i]);
    end
  end

  assign port.rdata  = rdata;
  assign port.rvalid = (|rslot) || rd_vendor || rd_arch;

  assign mtvec         = regs[SLOT_MTVEC];
  assign mepc          = regs[SLOT_MEPC];
  assign mstatus.raw   = regs[SLOT_MSTATUS];
  assign mcountinhibit = regs[SLOT_MCOUNTINHIBIT];

endmodule

`default_nettype wire

// File: rtl/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top import csr_pkg::*; #(
  parameter logic [XLEN-1:0] VENDOR_ID = 32'h79737978,
  parameter logic [XLEN-1:0] ARCH_ID   = 32'h015fde77
) (
  input  logic            clk,
  input  logic            rst,
  input  csr_addr_t       paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [XLEN-1:0] pwdata,
  output logic [XLEN-1:0] prdata,
  output logic            pready,
  output logic            pslverr,
  input  logic            trap_req,
  input  logic            mret_req,
  input  logic [XLEN-1:0] trap_pc,
  input  cause_t          trap_cause,
  output logic            trap_ack,
  output logic            redirect_valid,
  output logic [XLEN-1:0] redirect_pc
);

  csr_wr_if host_if ();  // apb slave to sequencer
  csr_wr_if csr_if ();   // sequencer to register file

  logic            grant;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcountinhibit;
  mstatus_t        mstatus_upd;
  logic            mstatus_we;
  logic            cnt_we_lo;
  logic            cnt_we_hi;
  logic [XLEN-1:0] cnt_wdata;
  logic [XLEN-1:0] cnt_lo;
  logic [XLEN-1:0] cnt_hi;

  csr_apb_slave csr_apb_slave_i (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .host    (host_if.master),
    .grant   (grant)
  );

  trap_fsm trap_fsm_i (
    .clk            (clk),
    .rst            (rst),
    .host           (host_if.file),
    .csr            (csr_if.master),
    .trap_req       (trap_req),
    .mret_req       (mret_req),
    .trap_pc        (trap_pc),
    .trap_cause     (trap_cause),
    .trap_ack       (trap_ack),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .mstatus_upd    (mstatus_upd),
    .mstatus_we     (mstatus_we),
    .cnt_we_lo      (cnt_we_lo),
    .cnt_we_hi      (cnt_we_hi),
    .cnt_wdata      (cnt_wdata),
    .cnt_rdata_lo   (cnt_lo),
    .cnt_rdata_hi   (cnt_hi),
    .grant          (grant)
  );

  csr_file #(
    .VENDOR_ID (VENDOR_ID),
    .ARCH_ID   (ARCH_ID)
  ) csr_file_i (
    .clk           (clk),
    .rst           (rst),
    .port          (csr_if.file),
    .mstatus_upd   (mstatus_upd),
    .mstatus_we    (mstatus_we),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .mstatus       (),
    .mcountinhibit (mcountinhibit)
  );

  cycle_counter cycle_counter_i (
    .clk      (clk),
    .rst      (rst),
    .inhibit  (mcountinhibit[0]), // CY bit
    .we_lo    (cnt_we_lo),
    .we_hi    (cnt_we_hi),
    .wdata    (cnt_wdata),
    .count_lo (cnt_lo),
    .count_hi (cnt_hi)
  );

endmodule

`default_nettype wire

// File: tests/csr_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_sva (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic trap_req,
  input logic mret_req,
  input logic trap_ack
);

  int fails = 0; // read by the testbench at the end

  //////////////////////////////////////////////////
  // trap port
  //////////////////////////////////////////////////
  property ack_after_req;
    @(posedge clk) disable iff (rst)
      (trap_req || mret_req) && !trap_ack |=> trap_ack;
  endproperty

  property ack_has_req;
    @(posedge clk) disable iff (rst)
      trap_ack |-> $past(trap_req || mret_req);
  endproperty

  property ack_single;
    @(posedge clk) disable iff (rst)
      trap_ack |=> !trap_ack;
  endproperty

  //////////////////////////////////////////////////
  // apb
  //////////////////////////////////////////////////
  // access phase follows a setup phase or a stalled access
  property pready_in_access;
    @(posedge clk) disable iff (rst)
      pready |-> psel && penable && $past(psel) && !$past(pready);
  endproperty

  a_ack_after_req: assert property (ack_after_req)
    else begin
      $error("trap_ack missing one cycle after request");
      fails++;
    end

  a_ack_has_req: assert property (ack_has_req)
    else begin
      $error("trap_ack without a request");
      fails++;
    end

  a_ack_single: assert property (ack_single)
    else begin
      $error("trap_ack high for two cycles");
      fails++;
    end

  a_pready_in_access: assert property (pready_in_access)
    else begin
      $error("pready outside an access phase");
      fails++;
    end

endmodule

`default_nettype wire

// File: tests/csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_checker import csr_pkg::*; #(
  parameter logic [XLEN-1:0] VENDOR_ID = 32'h79737978,
  parameter logic [XLEN-1:0] ARCH_ID   = 32'h015fde77
) (
  input  logic            clk,
  input  logic            rst,
  input  csr_addr_t       paddr,
  input  logic            pwrite,
  input  logic [XLEN-1:0] pwdata,
  input  logic [XLEN-1:0] prdata,
  input  logic            pready,
  input  logic            pslverr,
  input  logic            trap_req,
  input  logic            mret_req,
  input  logic [XLEN-1:0] trap_pc,
  input  cause_t          trap_cause,
  input  logic            trap_ack,
  input  logic            redirect_valid,
  input  logic [XLEN-1:0] redirect_pc,
  output int              errors,
  output int              checks
);

  localparam logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888; // mpp, mpie, mie
  localparam int              MIE          = 3;
  localparam int              MPIE         = 7;

  logic [XLEN-1:0]   m_mstatus;
  logic [XLEN-1:0]   m_mtvec;
  logic [XLEN-1:0]   m_mepc;
  logic [XLEN-1:0]   m_mcause;
  logic [XLEN-1:0]   m_inhibit;
  logic [2*XLEN-1:0] m_cycle;
  logic              ack_due; // request sampled, ack expected next cycle

  function automatic logic is_writable(csr_addr_t a);
    return a inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MCOUNTINHIBIT,
                     CSR_MCYCLE, CSR_MCYCLEH};
  endfunction

  function automatic logic is_known(csr_addr_t a);
    return is_writable(a) || a == CSR_MVENDORID || a == CSR_MARCHID;
  endfunction

  function automatic logic [XLEN-1:0] model_read(csr_addr_t a);
    case (a)
      CSR_MSTATUS:       return m_mstatus;
      CSR_MTVEC:         return m_mtvec;
      CSR_MEPC:          return m_mepc;
      CSR_MCAUSE:        return m_mcause;
      CSR_MCOUNTINHIBIT: return m_inhibit;
      CSR_MCYCLE:        return m_cycle[XLEN-1:0];
      CSR_MCYCLEH:       return m_cycle[2*XLEN-1:XLEN];
      CSR_MVENDORID:     return VENDOR_ID;
      CSR_MARCHID:       return ARCH_ID;
      default:           return '0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s expected %08h actual %08h", $time, name, exp, act);
    end
  endtask

  // model holds the state of the current cycle, advanced at each negedge
  always @(negedge clk) begin
    logic [2*XLEN-1:0] next_cycle;
    logic              exp_ack;
    if (rst) begin
      m_mstatus = '0;
      m_mtvec   = '0;
      m_mepc    = '0;
      m_mcause  = '0;
      m_inhibit = '0;
      m_cycle   = '0;
      ack_due   = 1'b0;
      errors    = 0;
      checks    = 0;
    end else begin
      next_cycle = m_inhibit[0] ? m_cycle : m_cycle + 64'd1;
      exp_ack    = ack_due;
      ack_due    = (trap_req || mret_req) && !exp_ack;
      compare("trap_ack", {31'b0, exp_ack}, {31'b0, trap_ack});
      compare("redirect_valid", {31'b0, exp_ack}, {31'b0, redirect_valid});
      if (pready && !pwrite) begin
        compare("pslverr", {31'b0, !is_known(paddr)}, {31'b0, pslverr});
        compare("prdata", model_read(paddr), prdata);
      end
      if (pready && pwrite) begin
        compare("pslverr", {31'b0, !is_writable(paddr)}, {31'b0, pslverr});
        case (paddr)
          CSR_MSTATUS:       m_mstatus = pwdata & MSTATUS_MASK;
          CSR_MTVEC:         m_mtvec   = {pwdata[XLEN-1:2], 2'b00};
          CSR_MEPC:          m_mepc    = {pwdata[XLEN-1:2], 2'b00};
          CSR_MCAUSE:        m_mcause  = pwdata;
          CSR_MCOUNTINHIBIT: m_inhibit = pwdata;
          CSR_MCYCLE:        next_cycle = {m_cycle[2*XLEN-1:XLEN], pwdata}; // no increment
          CSR_MCYCLEH:       next_cycle = {pwdata, m_cycle[XLEN-1:0]};
          default: ;
        endcase
      end
      if (exp_ack) begin
        if (trap_req) begin
          compare("redirect_pc", m_mtvec, redirect_pc);
          m_mepc          = {trap_pc[XLEN-1:2], 2'b00};
          m_mcause        = trap_cause;
          m_mstatus[MPIE] = m_mstatus[MIE];
          m_mstatus[MIE]  = 1'b0;
        end else begin
          compare("redirect_pc", m_mepc, redirect_pc); // mret
          m_mstatus[MIE]  = m_mstatus[MPIE];
          m_mstatus[MPIE] = 1'b1;
        end
      end
      m_cycle = next_cycle;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

  localparam logic [XLEN-1:0] VENDOR_ID = 32'h79737978;
  localparam logic [XLEN-1:0] ARCH_ID   = 32'h015fde77;
  localparam int              TIMEOUT   = 40; // cycles per wait

  logic            clk;
  logic            rst;
  csr_addr_t       paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [XLEN-1:0] pwdata;
  logic [XLEN-1:0] prdata;
  logic            pready;
  logic            pslverr;
  logic            trap_req;
  logic            mret_req;
  logic [XLEN-1:0] trap_pc;
  cause_t          trap_cause;
  logic            trap_ack;
  logic            redirect_valid;
  logic [XLEN-1:0] redirect_pc;

  integer seed;
  integer trap_seed;
  int     tb_errors;
  int     chk_errors;
  int     chk_count;
  int     stalls;
  int     err_mark;

  always #4 clk = ~clk;

  csr_unit_top #(
    .VENDOR_ID (VENDOR_ID),
    .ARCH_ID   (ARCH_ID)
  ) csr_unit_top_i (
    .clk            (clk),
    .rst            (rst),
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .trap_req       (trap_req),
    .mret_req       (mret_req),
    .trap_pc        (trap_pc),
    .trap_cause     (trap_cause),
    .trap_ack       (trap_ack),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  csr_checker #(
    .VENDOR_ID (VENDOR_ID),
    .ARCH_ID   (ARCH_ID)
  ) csr_checker_i (
    .clk            (clk),
    .rst            (rst),
    .paddr          (paddr),
    .pwrite         (pwrite),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .trap_req       (trap_req),
    .mret_req       (mret_req),
    .trap_pc        (trap_pc),
    .trap_cause     (trap_cause),
    .trap_ack       (trap_ack),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .errors         (chk_errors),
    .checks         (chk_count)
  );

  bind csr_unit_top csr_unit_sva csr_unit_sva_i (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pready   (pready),
    .trap_req (trap_req),
    .mret_req (mret_req),
    .trap_ack (trap_ack)
  );

  function automatic csr_addr_t pick_addr(int idx);
    case (idx)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MEPC;
      3:       return CSR_MCAUSE;
      4:       return CSR_MCOUNTINHIBIT;
      5:       return CSR_MVENDORID;
      6:       return CSR_MARCHID;
      7:       return 12'h7c0; // unmapped
      8:       return CSR_MCYCLE;
      default: return CSR_MCYCLEH;
    endcase
  endfunction

  function automatic int total_errors();
    return tb_errors + chk_errors + csr_unit_top_i.csr_unit_sva_i.fails;
  endfunction

  //////////////////////////////////////////////////
  // bus and core drivers
  //////////////////////////////////////////////////
  task automatic apb_xfer(input logic wr, input csr_addr_t addr, input logic [XLEN-1:0] wdata,
                          output logic [XLEN-1:0] rdata, output logic err);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    n     = 0;
    rdata = '0;
    err   = 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!pready && n < TIMEOUT);
    if (!pready) begin
      $display("timeout: APB transfer to %03h never completed", addr);
      tb_errors++;
    end else begin
      rdata = prdata;
      err   = pslverr;
      if (n > 1) stalls++;
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic core_request(input logic is_trap, input logic [XLEN-1:0] pc,
                              input cause_t cause);
    int n;
    @(posedge clk);
    trap_req   <= is_trap;
    mret_req   <= !is_trap;
    trap_pc    <= pc;
    trap_cause <= cause;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!trap_ack && n < TIMEOUT);
    if (!trap_ack) begin
      $display("timeout: no trap_ack for %s request", is_trap ? "trap" : "mret");
      tb_errors++;
    end
    @(posedge clk);
    trap_req <= 1'b0;
    mret_req <= 1'b0;
  endtask

  task automatic expect_value(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %08h actual %08h", $time, name, exp, act);
      tb_errors++;
    end
  endtask

  task automatic test_done(input string name);
    if (total_errors() == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, total_errors() - err_mark);
    end
    err_mark = total_errors();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] rnd;
    logic [XLEN-1:0] rnd2;
    logic [XLEN-1:0] lo;
    logic [XLEN-1:0] hi;
    logic            err;
    int              idx;
    clk        = 1'b0;
    rst        = 1'b1;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    trap_req   = 1'b0;
    mret_req   = 1'b0;
    trap_pc    = '0;
    trap_cause = '0;
    seed       = 23141;
    tb_errors  = 0;
    stalls     = 0;
    err_mark   = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 10; i++) begin
      apb_xfer(1'b0, pick_addr(i), '0, rd, err);
    end
    test_done("reset_values");

    for (int i = 0; i < 40; i++) begin
      idx = {$random(seed)} % 8;
      apb_xfer(1'b1, pick_addr(idx), $random(seed), rd, err);
      apb_xfer(1'b0, pick_addr(idx), '0, rd, err);
    end
    test_done("random_rw");

    for (int i = 0; i < 6; i++) begin
      apb_xfer(1'b1, CSR_MTVEC, $random(seed), rd, err);
      apb_xfer(1'b1, CSR_MSTATUS, $random(seed), rd, err);
      core_request(1'b1, $random(seed), (i == 0) ? CAUSE_ECALL_M : cause_t'($random(seed)));
      apb_xfer(1'b0, CSR_MEPC, '0, rd, err);
      apb_xfer(1'b0, CSR_MCAUSE, '0, rd, err);
      apb_xfer(1'b0, CSR_MSTATUS, '0, rd, err);
    end
    test_done("trap_entry");

    for (int i = 0; i < 6; i++) begin
      apb_xfer(1'b1, CSR_MEPC, $random(seed), rd, err);
      apb_xfer(1'b1, CSR_MSTATUS, $random(seed), rd, err);
      core_request(1'b0, '0, '0);
      apb_xfer(1'b0, CSR_MSTATUS, '0, rd, err);
    end
    test_done("mret");

    stalls    = 0;
    trap_seed = $random(seed);
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          rnd = $random(seed);
          apb_xfer(rnd[0], pick_addr({$random(seed)} % 10), $random(seed), rd, err);
        end
      end
      begin
        for (int i = 0; i < 12; i++) begin
          rnd2 = $random(trap_seed);
          repeat (rnd2[2:1]) @(posedge clk);
          core_request(rnd2[0], $random(trap_seed), $random(trap_seed));
        end
      end
    join
    if (stalls == 0) begin
      $display("no host access was stalled by a trap commit");
      tb_errors++;
    end
    test_done($sformatf("host_vs_trap (%0d stalled)", stalls));

    apb_xfer(1'b1, CSR_MCOUNTINHIBIT, 32'h1, rd, err);
    lo = $random(seed) & 32'h0fff_ffff; // far from wrap
    hi = $random(seed);
    apb_xfer(1'b1, CSR_MCYCLE, lo, rd, err);
    apb_xfer(1'b1, CSR_MCYCLEH, hi, rd, err);
    apb_xfer(1'b0, CSR_MCYCLE, '0, rd, err);
    expect_value("mcycle", lo, rd);
    apb_xfer(1'b0, CSR_MCYCLEH, '0, rd, err);
    expect_value("mcycleh", hi, rd);
    apb_xfer(1'b1, CSR_MCOUNTINHIBIT, 32'h0, rd, err);
    apb_xfer(1'b0, CSR_MCYCLE, '0, rd, err);
    apb_xfer(1'b0, CSR_MCYCLE, '0, rd2, err);
    if (rd2 <= rd) begin
      $display("mcycle did not increase between reads: %08h then %08h", rd, rd2);
      tb_errors++;
    end
    test_done("cycle_counter");

    $display("checks %0d, errors %0d", chk_count, total_errors());
    if (total_errors() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/csr_pkg.sv
rtl/csr_wr_if.sv
rtl/csr_apb_slave.sv
rtl/trap_fsm.sv
rtl/cycle_counter.sv
rtl/csr_file.sv
rtl/csr_unit_top.sv
tests/csr_unit_sva.sv
tests/csr_checker.sv
tests/tb_csr_unit.sv

// File: run.sh
#!/bin/sh
# build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr_unit \
  -f flist.f -o sim_csr_unit
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_csr_unit +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0
